// ==== Makefile ====
TOP := tb_board_reset

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/board_reset_top.sv ====
// Board reset sequencer top level with timer, debouncer and both FSMs.
`timescale 1ns/10ps

module board_reset_top (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic button_r,
   input  logic lpddr_calib_done,
   output logic lpddr_reset,
   output logic cpu_reset,
   output logic boot
);

   logic med_tick;
   logic slow_tick;
   logic cpu_tick;
   logic press;

   seq_link_if link ();

   tick_timer u_tick_timer (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .med_tick  (med_tick),
      .slow_tick (slow_tick),
      .cpu_tick  (cpu_tick)
   );

   button_debounce u_button_debounce (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .slow_tick (slow_tick),
      .button_r  (button_r),
      .press     (press)
   );

   sys_reset_seq u_sys_reset_seq (
      .sysclk           (sysclk),
      .dcm_reset        (dcm_reset),
      .med_tick         (med_tick),
      .press            (press),
      .lpddr_calib_done (lpddr_calib_done),
      .link             (link.sys_side),
      .lpddr_reset      (lpddr_reset)
   );

   cpu_boot_seq u_cpu_boot_seq (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .cpu_tick  (cpu_tick),
      .link      (link.cpu_side),
      .boot      (boot)
   );

   // Processor held in reset by either side.
   assign cpu_reset = link.sys_in_reset | link.cpu_in_reset;

endmodule : board_reset_top

// ==== design/board_types_pkg.sv ====
// Vector types for tick counters, the holdoff counter and button samples.

package board_types_pkg;

   // ------------------------------------------------------------
   // Divider counters. Widths are the maximum needed on the board.
   // ------------------------------------------------------------
   typedef logic [5:0]  med_cnt_t;
   typedef logic [11:0] slow_cnt_t;

   // Memory reset holdoff after the clock manager releases reset.
   typedef logic [3:0]  holdoff_cnt_t;

   // Button samples, newest in bit 0.
   typedef logic [9:0]  press_hist_t;

endpackage : board_types_pkg

// ==== design/button_debounce.sv ====
// Slow-tick sampler and single press pulse for the reset button.
`timescale 1ns/10ps
`include "reset_seq_cfg.svh"

module button_debounce
   import board_types_pkg::*;
(
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic slow_tick,
   input  logic button_r,
   output logic press
);

   press_hist_t hist;
   logic        detected;
   logic        detected_q;

   // Stable press once the newest samples are all high.
   assign detected = &hist[`DEBOUNCE_DEPTH-1:0];

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         hist       <= '0;
         detected_q <= 1'b0;
      end else if (slow_tick) begin
         hist       <= {hist[8:0], button_r};
         detected_q <= detected;
      end
   end

   // ------------------------------------------------------------
   // One pulse on the slow tick where the detection first shows.
   // A held button keeps detected high and gives no more pulses.
   // ------------------------------------------------------------
   assign press = slow_tick & detected & ~detected_q;

endmodule : button_debounce

// ==== design/cpu_boot_seq.sv ====
// CPU-side reset FSM driving the processor reset and boot strobe.
`timescale 1ns/10ps

module cpu_boot_seq
   import seq_states_pkg::*;
(
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic cpu_tick,
   seq_link_if.cpu_side link,
   output logic boot
);

   cpu_state_t state;
   cpu_state_t state_next;
   logic       sys_ready;

   // System side has dropped its request and left reset.
   assign sys_ready = ~link.boot_req & ~link.sys_in_reset;

   always_comb begin
      state_next = state;
      case (state)
         c_init, c_idle: begin
            if (link.boot_req)
               state_next = c_reset1;
         end
         c_reset1: state_next = c_reset2;
         c_reset2: state_next = c_boot;
         c_boot:   state_next = c_wait;
         c_wait: begin
            if (sys_ready)
               state_next = c_idle;
         end
         default:  state_next = c_init;
      endcase
   end

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         state <= c_init;
      end else if (cpu_tick) begin
         state <= state_next;
      end
   end

   // ------------------------------------------------------------
   // Outputs. Boot spans c_reset2 and c_boot for two CPU ticks.
   // ------------------------------------------------------------
   assign link.cpu_in_reset = (state inside {c_init, c_reset1, c_reset2});
   assign link.cpu_running  = (state == c_idle);
   assign boot              = (state inside {c_reset2, c_boot});

   // No boot strobe while the system side holds the board in reset.
   a_no_boot_in_sys_reset : assert property (
      @(posedge sysclk) disable iff (dcm_reset)
      link.sys_in_reset |-> !boot
   );

endmodule : cpu_boot_seq

// ==== design/seq_link_if.sv ====
// Request and status link between the system and CPU sequencers.
`timescale 1ns/10ps

interface seq_link_if;

   logic boot_req;
   logic sys_in_reset;
   logic cpu_in_reset;
   logic cpu_running;

   modport sys_side (
      output boot_req,
      output sys_in_reset,
      input  cpu_in_reset,
      input  cpu_running
   );

   modport cpu_side (
      input  boot_req,
      input  sys_in_reset,
      output cpu_in_reset,
      output cpu_running
   );

endinterface : seq_link_if

// ==== design/seq_states_pkg.sv ====
// State encodings of the system and CPU reset sequencers.

package seq_states_pkg;

   // ------------------------------------------------------------
   // System side. Memory reset, calibration, then boot request.
   // ------------------------------------------------------------
   typedef enum logic [2:0] {
      s_init,
      s_mem_reset,
      s_settle,
      s_calib_wait,
      s_boot_req,
      s_run_wait,
      s_idle
   } sys_state_t;

   // ------------------------------------------------------------
   // CPU side. Reset, boot strobe, then run.
   // ------------------------------------------------------------
   typedef enum logic [2:0] {
      c_init,
      c_reset1,
      c_reset2,
      c_boot,
      c_wait,
      c_idle
   } cpu_state_t;

endpackage : seq_states_pkg

// ==== design/sys_reset_seq.sv ====
// System-side reset FSM with the memory reset holdoff counter.
`timescale 1ns/10ps
`include "reset_seq_cfg.svh"

module sys_reset_seq
   import board_types_pkg::*;
   import seq_states_pkg::*;
(
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic med_tick,
   input  logic press,
   input  logic lpddr_calib_done,
   seq_link_if.sys_side link,
   output logic lpddr_reset
);

   sys_state_t   state;
   sys_state_t   state_next;
   holdoff_cnt_t holdoff_cnt;
   logic         holdoff_done;
   logic         pending;
   logic         consume;

   // ------------------------------------------------------------
   // Holdoff counts once after dcm_reset. Presses do not restart it.
   // ------------------------------------------------------------
   assign holdoff_done = (holdoff_cnt == holdoff_cnt_t'(`HOLDOFF_CYCLES));

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         holdoff_cnt <= '0;
      end else if (!holdoff_done) begin
         holdoff_cnt <= holdoff_cnt + holdoff_cnt_t'(1);
      end
   end

   // Press is taken only where the CPU side is known to be running.
   assign consume = med_tick & pending &
                    ((state == s_run_wait && link.cpu_running) || state == s_idle);

   always_comb begin
      state_next = state;
      case (state)
         s_init:       state_next = s_mem_reset;
         s_mem_reset:  state_next = s_settle;
         s_settle:     state_next = s_calib_wait;
         s_calib_wait: begin
            if (lpddr_calib_done)
               state_next = s_boot_req;
         end
         s_boot_req: begin
            if (!link.cpu_running)
               state_next = s_run_wait;
         end
         s_run_wait: begin
            if (consume)
               state_next = s_mem_reset;
            else if (link.cpu_running)
               state_next = s_idle;
         end
         s_idle: begin
            if (consume)
               state_next = s_mem_reset;
         end
         default:      state_next = s_init;
      endcase
   end

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         state   <= s_init;
         pending <= 1'b0;
      end else begin
         pending <= (pending & ~consume) | press;
         if (med_tick)
            state <= state_next;
      end
   end

   assign link.boot_req     = (state == s_boot_req);
   assign link.sys_in_reset = (state inside {s_init, s_mem_reset, s_settle, s_calib_wait});
   assign lpddr_reset       = (state inside {s_init, s_mem_reset}) & holdoff_done;

   // Memory reset stays low until the holdoff after dcm_reset has passed.
   a_holdoff_quiet : assert property (
      @(posedge sysclk) disable iff (dcm_reset)
      lpddr_reset |-> !$past(dcm_reset, `HOLDOFF_CYCLES)
   );

endmodule : sys_reset_seq

// ==== design/tick_timer.sv ====
// Free-running dividers for the medium, slow and CPU step ticks.
`timescale 1ns/10ps
`include "reset_seq_cfg.svh"

module tick_timer
   import board_types_pkg::*;
(
   input  logic sysclk,
   input  logic dcm_reset,
   output logic med_tick,
   output logic slow_tick,
   output logic cpu_tick
);

   med_cnt_t  med_cnt;
   slow_cnt_t slow_cnt;
   med_cnt_t  cpu_cnt;

   // Each counter wraps at its divider and ticks on the wrap.
   assign med_tick  = (med_cnt == med_cnt_t'(`MED_DIV - 1));
   assign slow_tick = (slow_cnt == slow_cnt_t'(`SLOW_DIV - 1));
   assign cpu_tick  = (cpu_cnt == med_cnt_t'(`CPU_DIV - 1));

   always_ff @(posedge sysclk or posedge dcm_reset) begin
      if (dcm_reset) begin
         med_cnt  <= '0;
         slow_cnt <= '0;
         cpu_cnt  <= '0;
      end else begin
         med_cnt  <= med_tick ? '0 : med_cnt + med_cnt_t'(1);
         slow_cnt <= slow_tick ? '0 : slow_cnt + slow_cnt_t'(1);
         cpu_cnt  <= cpu_tick ? '0 : cpu_cnt + med_cnt_t'(1);
      end
   end

   // The system FSM relies on med_tick being a single-cycle strobe.
   a_med_tick_single : assert property (
      @(posedge sysclk) disable iff (dcm_reset)
      med_tick |=> !med_tick
   );

endmodule : tick_timer

// ==== include/reset_seq_cfg.svh ====
// Divider, holdoff and debounce settings of the reset sequencer.
`ifndef RESET_SEQ_CFG_SVH
`define RESET_SEQ_CFG_SVH

// Sysclk cycles per medium tick (board value is 64).
`define MED_DIV 4

// Sysclk cycles per slow tick (board value is 4096).
`define SLOW_DIV 16

// Sysclk cycles per CPU step tick.
`define CPU_DIV 4

// Sysclk cycles of memory reset holdoff.
`define HOLDOFF_CYCLES 4

// Consecutive high samples for a press, at most 10.
`define DEBOUNCE_DEPTH 4

`endif

// ==== src.f ====
+incdir+include
design/board_types_pkg.sv
design/seq_states_pkg.sv
design/seq_link_if.sv
design/tick_timer.sv
design/button_debounce.sv
design/sys_reset_seq.sv
design/cpu_boot_seq.sv
design/board_reset_top.sv
testbench/tb_board_reset.sv

// ==== testbench/reset_stim.txt ====
# Reset sequencer stimulus, one command per line.
# calib <level> | press <hold cycles> | expect_boots <total> | expect_levels <lpddr_reset> <cpu_reset>
#
# Calibration gate, no boot while calib is low.
calib 0
expect_boots 0
expect_levels 0 1
# First boot after calibration.
calib 1
expect_boots 1
expect_levels 0 0
# Debounced press restarts the sequence.
press 100
expect_boots 2
expect_levels 0 0
# Short glitch is ignored.
press 10
expect_boots 2
# Long hold still gives one restart.
press 1000
expect_boots 3
expect_levels 0 0

// ==== testbench/tb_board_reset.sv ====
// Testbench for the board reset sequencer: clock, reset, stimulus reader, monitor and checks.
`timescale 1ns/10ps
`include "reset_seq_cfg.svh"

module tb_board_reset
   import board_types_pkg::*;
();

   localparam int BOOT_TIMEOUT = 4000;
   localparam int QUIET_WINDOW = 300;

   logic sysclk = 1'b0;
   logic dcm_reset;
   logic button_r;
   logic lpddr_calib_done;
   logic lpddr_reset;
   logic cpu_reset;
   logic boot;

   // Monitor state.
   int        cyc;
   int        boot_count;
   int        boots_no_mem;
   logic      mem_reset_seen;
   logic      rise_seen;
   int        rise_cyc;
   logic      lpddr_q;
   logic      boot_q;
   slow_cnt_t width;
   slow_cnt_t widths[$];

   board_reset_top dut0 (
      .sysclk           (sysclk),
      .dcm_reset        (dcm_reset),
      .button_r         (button_r),
      .lpddr_calib_done (lpddr_calib_done),
      .lpddr_reset      (lpddr_reset),
      .cpu_reset        (cpu_reset),
      .boot             (boot)
   );

   always #5 sysclk = ~sysclk;

   // ------------------------------------------------------------
   // Boot pulse counter, width recorder and memory reset tracker.
   // ------------------------------------------------------------
   always @(posedge sysclk) begin
      if (dcm_reset) begin
         cyc            = 0;
         boot_count     = 0;
         boots_no_mem   = 0;
         mem_reset_seen = 1'b0;
         rise_seen      = 1'b0;
         rise_cyc       = 0;
         lpddr_q        = 1'b0;
         boot_q         = 1'b0;
         width          = '0;
      end else begin
         if (lpddr_reset && !lpddr_q) begin
            mem_reset_seen = 1'b1;
            if (!rise_seen) begin
               rise_seen = 1'b1;
               rise_cyc  = cyc;
            end
         end
         if (boot && !boot_q) begin
            boot_count = boot_count + 1;
            if (!mem_reset_seen)
               boots_no_mem = boots_no_mem + 1;
            mem_reset_seen = 1'b0;
            width          = slow_cnt_t'(1);
         end else if (boot) begin
            width = width + slow_cnt_t'(1);
         end
         if (!boot && boot_q)
            widths.push_back(width);
         lpddr_q = lpddr_reset;
         boot_q  = boot;
         cyc     = cyc + 1;
      end
   end

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_failure(input string why);
      $display("%s", why);
      abort_run();
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("ERROR: %s expected %0d actual %0d", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERROR: %s expected %b actual %b", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_width(input string name, input slow_cnt_t expected,
                              input slow_cnt_t actual);
      if (actual != expected) begin
         $display("ERROR: %s expected %0d actual %0d", name, expected, actual);
         abort_run();
      end
   endtask

   // Waits for the boot count, then watches a quiet window for extra pulses.
   task automatic expect_boots(input int lineno, input int count);
      int t;
      t = 0;
      while (boot_count < count && t < BOOT_TIMEOUT) begin
         @(negedge sysclk);
         t = t + 1;
      end
      if (boot_count < count)
         report_failure($sformatf("Timeout: boot pulse %0d never came (line %0d)", count, lineno));
      for (int i = 0; i < QUIET_WINDOW; i++)
         @(negedge sysclk);
      check_count($sformatf("line %0d boot count", lineno), count, boot_count);
      check_count($sformatf("line %0d boots without memory reset", lineno), 0, boots_no_mem);
      while (widths.size() > 0)
         check_width($sformatf("line %0d boot width", lineno),
                     slow_cnt_t'(2 * `CPU_DIV), widths.pop_front());
   endtask

   initial begin
      int    fd;
      int    n;
      int    lineno;
      int    a;
      int    b;
      string text;
      string cmd;
      dcm_reset        = 1'b1;
      button_r         = 1'b0;
      lpddr_calib_done = 1'b0;
      lineno           = 0;
      repeat (10) @(negedge sysclk);
      dcm_reset = 1'b0;

      fd = $fopen("testbench/reset_stim.txt", "r");
      if (fd == 0)
         report_failure("Could not open the stimulus file testbench/reset_stim.txt");
      while (!$feof(fd)) begin
         text   = "";
         n      = $fgets(text, fd);
         lineno = lineno + 1;
         a      = 0;
         b      = 0;
         if (n > 0 && text.len() > 1 && text.getc(0) != "#") begin
            n = $sscanf(text, "%s %d %d", cmd, a, b);
            if (cmd == "calib") begin
               lpddr_calib_done = a[0];
            end else if (cmd == "press") begin
               button_r = 1'b1;
               for (int i = 0; i < a; i++)
                  @(negedge sysclk);
               button_r = 1'b0;
            end else if (cmd == "expect_boots") begin
               expect_boots(lineno, a);
            end else if (cmd == "expect_levels") begin
               check_bit($sformatf("line %0d lpddr_reset", lineno), a[0], lpddr_reset);
               check_bit($sformatf("line %0d cpu_reset", lineno), b[0], cpu_reset);
            end else begin
               report_failure($sformatf("Unknown command on stimulus line %0d", lineno));
            end
         end
      end
      $fclose(fd);

      // Memory reset rose only after the holdoff.
      check_bit("holdoff rise seen", 1'b1, rise_seen);
      check_bit("holdoff length", 1'b1, rise_cyc >= `HOLDOFF_CYCLES);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule : tb_board_reset
